//--- list.f
videoPkg.sv
patternSource.sv
pixelFifo.sv
displayTiming.sv
videoPreProcessor.sv
tbVideo_assert.sv
tbVideo.sv

//--- run.sh
#!/bin/sh
# Compile and run the video front end testbench with Verilator.
# Pass or fail is taken from the simulation log.
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tbVideo -f list.f
./obj_dir/VtbVideo +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log
if grep -qF '*** TEST PASSED ***' sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

//--- tbVideo.sv
/*
 * Testbench for the display front end.
 * Runs each row of the stimulus table after a reset and follows the
 * expected h/v position strobe by strobe. Checks pixels, sync flags,
 * per-line and per-frame counts, then prints one result line.
 * Built and run by run.sh.
 */
`timescale 1ns/1ns

module tbVideo
    import videoPkg::*;
();

    localparam int hDisplay    = 16;
    localparam int hBack       = 3;
    localparam int hFront      = 2;
    localparam int hSync       = 4;
    localparam int vDisplay    = 6;
    localparam int vTop        = 2;
    localparam int vBottom     = 1;
    localparam int vSync       = 2;
    localparam int pClkDiv     = 8;
    localparam int fifoDepth   = 8;
    localparam int hTotal      = hDisplay + hFront + hSync + hBack;
    localparam int vTotal      = vDisplay + vBottom + vSync + vTop;
    localparam int hSyncStart  = hDisplay + hFront;
    localparam int vSyncStart  = vDisplay + vBottom;
    localparam int frameClocks = hTotal * vTotal * pClkDiv;
    localparam int numRows     = 4;

    // Pattern and frame count of each table row
    patternT rowPattern [numRows] = '{patGradient, patBars, patChecker, patSolid};
    int      rowFrames  [numRows] = '{2, 1, 1, 1};

    logic       iClk;
    logic       arstN;
    patternT    pattern;
    logic       vde;
    logic       fe;
    logic       fvde;
    logic       hsync;
    logic       vsync;
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;
    logic       underflow;

    int errors;
    int checks;
    int cycles;
    int cycleLimit;
    // Expected position and running counts
    int h;
    int v;
    int vdeInLine;
    int hsyncInLine;
    int vdeLines;
    int vsyncLines;
    int feSeen;

    videoPreProcessor #(
        .hDisplay  (hDisplay),
        .hBack     (hBack),
        .hFront    (hFront),
        .hSync     (hSync),
        .vDisplay  (vDisplay),
        .vTop      (vTop),
        .vBottom   (vBottom),
        .vSync     (vSync),
        .pClkDiv   (pClkDiv),
        .fifoDepth (fifoDepth)
    ) DUT (
        .iClk      (iClk),
        .arstN     (arstN),
        .pattern   (pattern),
        .vde       (vde),
        .fe        (fe),
        .fvde      (fvde),
        .hsync     (hsync),
        .vsync     (vsync),
        .red       (red),
        .green     (green),
        .blue      (blue),
        .underflow (underflow)
    );

    always #20 iClk = ~iClk;

    // Run limit
    always @(posedge iClk) begin
        cycles = cycles + 1;
        if (cycles > cycleLimit) begin
            $display("Timeout: run did not finish within %0d clock cycles", cycleLimit);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    //------------------------------------------------------------
    // Compare tasks
    //------------------------------------------------------------
    task automatic checkPixel(input rgbT got, input rgbT exp, input string what);
        checks = checks + 1;
        if (got !== exp) begin
            errors = errors + 1;
            $display("FAILED at %0t: %s pixel %06h, expected %06h", $time, what, got, exp);
        end
    endtask

    task automatic checkFlag(input bit got, input bit exp, input string what);
        checks = checks + 1;
        if (got != exp) begin
            errors = errors + 1;
            $display("FAILED at %0t: %s is %0b, expected %0b", $time, what, got, exp);
        end
    endtask

    task automatic checkCount(input int got, input int exp, input string what);
        checks = checks + 1;
        if (got != exp) begin
            errors = errors + 1;
            $display("FAILED at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    //------------------------------------------------------------
    // Reset and per-strobe model
    //------------------------------------------------------------
    task automatic applyReset(input patternT pat);
        @(posedge iClk);
        arstN   <= 1'b0;
        pattern <= pat;
        repeat (4) @(posedge iClk);
        arstN   <= 1'b1;
    endtask

    task automatic checkStrobe(input patternT pat);
        bit    expVde;
        rgbT   expPix;
        string where;
        expVde = (h < hDisplay) && (v < vDisplay);
        // x and y come from counting vde strobes and vde lines
        expPix = expVde ? patternPixel(pat, vdeInLine, vdeLines, hDisplay) : rgbT'(24'h0);
        where  = $sformatf("h=%0d v=%0d", h, v);
        checkFlag(vde, expVde, {"vde at ", where});
        checkFlag(fe, expVde && (h == hDisplay - 1) && (v == vDisplay - 1), {"fe at ", where});
        checkFlag(fvde, expVde && (v == 0), {"fvde at ", where});
        checkFlag(hsync, (h >= hSyncStart) && (h < hSyncStart + hSync), {"hsync at ", where});
        checkFlag(vsync, (v >= vSyncStart) && (v < vSyncStart + vSync), {"vsync at ", where});
        checkFlag(underflow, 1'b0, {"underflow at ", where});
        checkPixel(rgbT'({red, green, blue}), expPix, where);
        vdeInLine   = vdeInLine + int'(vde);
        hsyncInLine = hsyncInLine + int'(hsync);
        feSeen      = feSeen + int'(fe);
        if (h == hTotal - 1) begin
            checkCount(vdeInLine, (v < vDisplay) ? hDisplay : 0, "vde strobes in line");
            checkCount(hsyncInLine, hSync, "hsync strobes in line");
            vdeLines    = vdeLines + ((vdeInLine > 0) ? 1 : 0);
            vsyncLines  = vsyncLines + int'(vsync);
            vdeInLine   = 0;
            hsyncInLine = 0;
            h           = 0;
            if (v == vTotal - 1) begin
                checkCount(vdeLines, vDisplay, "lines with vde in frame");
                checkCount(vsyncLines, vSync, "vsync lines in frame");
                checkCount(feSeen, 1, "fe pulses in frame");
                vdeLines   = 0;
                vsyncLines = 0;
                feSeen     = 0;
                v          = 0;
            end else begin
                v = v + 1;
            end
        end else begin
            h = h + 1;
        end
    endtask

    task automatic runRow(input patternT pat, input int frames);
        applyReset(pat);
        @(negedge iClk);
        // Quiet outputs before the first strobe
        checkFlag(vde, 1'b0, "vde after reset");
        checkFlag(hsync, 1'b0, "hsync after reset");
        checkFlag(vsync, 1'b0, "vsync after reset");
        checkFlag(fe, 1'b0, "fe after reset");
        checkFlag(underflow, 1'b0, "underflow after reset");
        checkPixel(rgbT'({red, green, blue}), rgbT'(24'h0), "after reset");
        h           = 0;
        v           = 0;
        vdeInLine   = 0;
        hsyncInLine = 0;
        vdeLines    = 0;
        vsyncLines  = 0;
        feSeen      = 0;
        repeat (frames * hTotal * vTotal) begin
            repeat (pClkDiv) @(posedge iClk);
            @(negedge iClk);
            checkStrobe(pat);
        end
    endtask

    //------------------------------------------------------------
    // Main sequence
    //------------------------------------------------------------
    initial begin
        int totalFrames;
        int assertFails;
        iClk        = 1'b0;
        arstN       = 1'b0;
        pattern     = patGradient;
        errors      = 0;
        checks      = 0;
        cycles      = 0;
        totalFrames = 0;
        foreach (rowFrames[i]) begin
            totalFrames = totalFrames + rowFrames[i];
        end
        cycleLimit = totalFrames * frameClocks * 6 / 5;
        for (int row = 0; row < numRows; row++) begin
            runRow(rowPattern[row], rowFrames[row]);
        end
        assertFails = DUT.FIFO.FIFOCHECK.failures + DUT.DTB.TIMINGCHECK.failures;
        $display("Checks: %0d, value errors: %0d, assertion failures: %0d",
                 checks, errors, assertFails);
        if (errors == 0 && assertFails == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- tbVideo_assert.sv
/*
 * Handshake and sync rules of the display front end.
 * Bound into the pixel FIFO for the req/ack rules and into the display
 * timing for the pop and fe rules. Inputs an instance does not use are
 * tied low, which leaves its other rules idle.
 */
`timescale 1ns/1ns

module tbVideo_assert (
    input logic iClk,
    input logic arstN,
    input logic req,
    input logic ack,
    input logic pop,
    input logic vde,
    input logic fe
);

    int failures = 0;

    // Four-phase order on the write side
    reqHoldsUntilAck: assert property (@(posedge iClk) disable iff (!arstN)
        $fell(req) |-> $past(ack))
        else begin
            failures = failures + 1;
            $error("req dropped before ack was raised");
        end

    ackNeedsReq: assert property (@(posedge iClk) disable iff (!arstN)
        $rose(ack) |-> $past(req))
        else begin
            failures = failures + 1;
            $error("ack rose without a pending req");
        end

    // Consumer side
    popOnlyInVde: assert property (@(posedge iClk) disable iff (!arstN)
        pop |-> vde)
        else begin
            failures = failures + 1;
            $error("pop outside the active area");
        end

    feOnlyInVde: assert property (@(posedge iClk) disable iff (!arstN)
        fe |-> vde)
        else begin
            failures = failures + 1;
            $error("fe high without vde");
        end

endmodule

bind pixelFifo tbVideo_assert FIFOCHECK (
    .iClk  (iClk),
    .arstN (arstN),
    .req   (req),
    .ack   (ack),
    .pop   (1'b0),
    .vde   (1'b0),
    .fe    (1'b0)
);

bind displayTiming tbVideo_assert TIMINGCHECK (
    .iClk  (iClk),
    .arstN (arstN),
    .req   (1'b0),
    .ack   (1'b0),
    .pop   (pop),
    .vde   (vde),
    .fe    (fe)
);

//--- videoPreProcessor.sv
/*
 * Top level of the display front end.
 * Sets the video geometry and wires pattern source, pixel FIFO and
 * display timing. Keep pClkDiv at 4 or more, since one req/ack
 * transfer takes four clocks and the source must keep pace.
 */
`timescale 1ns/1ns

module videoPreProcessor import videoPkg::*; #(
    parameter int hDisplay  = 640,
    parameter int hBack     = 48,
    parameter int hFront    = 16,
    parameter int hSync     = 96,
    parameter int vDisplay  = 480,
    parameter int vTop      = 31,
    parameter int vBottom   = 11,
    parameter int vSync     = 2,
    parameter int pClkDiv   = 4,
    parameter int fifoDepth = 16
)(
    input  logic       iClk,
    input  logic       arstN,
    input  patternT    pattern,
    output logic       vde,
    output logic       fe,
    output logic       fvde,
    output logic       hsync,
    output logic       vsync,
    output logic [7:0] red,
    output logic [7:0] green,
    output logic [7:0] blue,
    output logic       underflow
);

    // Producer to buffer handshake
    logic req;
    logic ack;
    rgbT  pixData;

    // Buffer to consumer
    logic empty;
    logic pop;
    rgbT  head;

    patternSource #(
        .hDisplay (hDisplay),
        .vDisplay (vDisplay)
    ) PSRC (
        .iClk     (iClk),
        .arstN    (arstN),
        .pattern  (pattern),
        .req      (req),
        .data     (pixData),
        .ack      (ack)
    );

    pixelFifo #(
        .payloadT  (rgbT),
        .fifoDepth (fifoDepth)
    ) FIFO (
        .iClk      (iClk),
        .arstN     (arstN),
        .req       (req),
        .data      (pixData),
        .ack       (ack),
        .empty     (empty),
        .head      (head),
        .pop       (pop)
    );

    displayTiming #(
        .hDisplay  (hDisplay),
        .hBack     (hBack),
        .hFront    (hFront),
        .hSync     (hSync),
        .vDisplay  (vDisplay),
        .vTop      (vTop),
        .vBottom   (vBottom),
        .vSync     (vSync),
        .pClkDiv   (pClkDiv)
    ) DTB (
        .iClk      (iClk),
        .arstN     (arstN),
        .empty     (empty),
        .head      (head),
        .pop       (pop),
        .vde       (vde),
        .fe        (fe),
        .fvde      (fvde),
        .hsync     (hsync),
        .vsync     (vsync),
        .red       (red),
        .green     (green),
        .blue      (blue),
        .underflow (underflow)
    );

endmodule

//--- displayTiming.sv
/*
 * Display timing generator and pixel consumer.
 * A divider makes a pixel strobe every pClkDiv clocks. The h/v counters
 * decode sync, vde, fe and fvde, all registered on the strobe. Each
 * active strobe takes the FIFO head onto red/green/blue and pops it.
 * An empty FIFO at that point gives black and a sticky underflow.
 */
`timescale 1ns/1ns

module displayTiming import videoPkg::*; #(
    parameter int hDisplay = 640,
    parameter int hBack    = 48,
    parameter int hFront   = 16,
    parameter int hSync    = 96,
    parameter int vDisplay = 480,
    parameter int vTop     = 31,
    parameter int vBottom  = 11,
    parameter int vSync    = 2,
    parameter int pClkDiv  = 4
)(
    input  logic       iClk,
    input  logic       arstN,
    input  logic       empty,
    input  rgbT        head,
    output logic       pop,
    output logic       vde,
    output logic       fe,
    output logic       fvde,
    output logic       hsync,
    output logic       vsync,
    output logic [7:0] red,
    output logic [7:0] green,
    output logic [7:0] blue,
    output logic       underflow
);

    localparam int hTotal     = hDisplay + hFront + hSync + hBack;
    localparam int vTotal     = vDisplay + vBottom + vSync + vTop;
    localparam int hSyncStart = hDisplay + hFront;
    localparam int vSyncStart = vDisplay + vBottom;
    localparam int hW         = $clog2(hTotal);
    localparam int vW         = $clog2(vTotal);
    localparam int divW       = (pClkDiv > 1) ? $clog2(pClkDiv) : 1;

    logic [divW-1:0] divCnt;
    logic            strobe;
    logic [hW-1:0]   hCnt;
    logic [vW-1:0]   vCnt;
    logic            active;
    logic            lastPixel;
    logic            hsyncNext;
    logic            vsyncNext;

    //------------------------------------------------------------
    // Pixel strobe
    //------------------------------------------------------------
    assign strobe = (divCnt == divW'(pClkDiv - 1));

    always_ff @(posedge iClk or negedge arstN) begin
        if (!arstN) begin
            divCnt <= '0;
        end else begin
            divCnt <= strobe ? '0 : divCnt + 1'b1;
        end
    end

    // Decode of the current counter position
    assign active    = (hCnt < hDisplay) && (vCnt < vDisplay);
    assign lastPixel = (hCnt == hW'(hDisplay - 1)) && (vCnt == vW'(vDisplay - 1));
    assign hsyncNext = (hCnt >= hSyncStart) && (hCnt < hSyncStart + hSync);
    assign vsyncNext = (vCnt >= vSyncStart) && (vCnt < vSyncStart + vSync);

    //------------------------------------------------------------
    // Counters and registered outputs
    //------------------------------------------------------------
    always_ff @(posedge iClk or negedge arstN) begin
        if (!arstN) begin
            hCnt      <= '0;
            vCnt      <= '0;
            vde       <= 1'b0;
            fe        <= 1'b0;
            fvde      <= 1'b0;
            hsync     <= 1'b0;
            vsync     <= 1'b0;
            pop       <= 1'b0;
            red       <= '0;
            green     <= '0;
            blue      <= '0;
            underflow <= 1'b0;
        end else begin
            // Pop lasts one clock, right after the strobe that took head
            pop <= 1'b0;
            if (strobe) begin
                if (hCnt == hW'(hTotal - 1)) begin
                    hCnt <= '0;
                    vCnt <= (vCnt == vW'(vTotal - 1)) ? '0 : vCnt + 1'b1;
                end else begin
                    hCnt <= hCnt + 1'b1;
                end
                vde   <= active;
                fe    <= active && lastPixel;
                fvde  <= active && (vCnt == '0);
                hsync <= hsyncNext;
                vsync <= vsyncNext;
                if (active && !empty) begin
                    red   <= head.red;
                    green <= head.green;
                    blue  <= head.blue;
                    pop   <= 1'b1;
                end else begin
                    red   <= '0;
                    green <= '0;
                    blue  <= '0;
                    if (active) begin
                        underflow <= 1'b1;
                    end
                end
            end
        end
    end

endmodule

//--- pixelFifo.sv
/*
 * Pixel buffer between the pattern source and the display timing.
 * Write side is a four-phase req/ack slave that withholds ack while
 * full. Read side is show-ahead: head shows the oldest word and pop
 * drops it.
 */
`timescale 1ns/1ns

module pixelFifo #(
    parameter type payloadT  = logic [23:0],
    parameter int  fifoDepth = 16
)(
    input  logic    iClk,
    input  logic    arstN,
    input  logic    req,
    input  payloadT data,
    output logic    ack,
    output logic    empty,
    output payloadT head,
    input  logic    pop
);

    localparam int ptrW = (fifoDepth > 1) ? $clog2(fifoDepth) : 1;
    localparam int cntW = $clog2(fifoDepth + 1);

    payloadT         mem [fifoDepth];
    logic [ptrW-1:0] wrPtr;
    logic [ptrW-1:0] rdPtr;
    logic [cntW-1:0] count;
    logic            full;
    logic            wrEn;
    logic            rdEn;

    function automatic logic [ptrW-1:0] nextPtr(input logic [ptrW-1:0] ptr);
        return (ptr == ptrW'(fifoDepth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full  = (count == cntW'(fifoDepth));
    assign empty = (count == '0);
    // Only a fresh req is written, never the one already acked
    assign wrEn  = req && !ack && !full;
    assign rdEn  = pop && !empty;
    assign head  = mem[rdPtr];

    always_ff @(posedge iClk) begin
        if (wrEn) begin
            mem[wrPtr] <= data;
        end
    end

    //------------------------------------------------------------
    // Pointers, occupancy and ack
    //------------------------------------------------------------
    always_ff @(posedge iClk or negedge arstN) begin
        if (!arstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
            ack   <= 1'b0;
        end else begin
            if (wrEn) begin
                wrPtr <= nextPtr(wrPtr);
                ack   <= 1'b1;
            end else if (!req) begin
                ack   <= 1'b0;
            end
            if (rdEn) begin
                rdPtr <= nextPtr(rdPtr);
            end
            case ({wrEn, rdEn})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- patternSource.sv
/*
 * Pattern source of the display front end.
 * Walks x and y over the active frame and offers one pixel per
 * four-phase req/ack transfer. The pattern is taken while reset is
 * held, so a new pattern needs a reset.
 */
`timescale 1ns/1ns

module patternSource import videoPkg::*; #(
    parameter int hDisplay = 640,
    parameter int vDisplay = 480
)(
    input  logic    iClk,
    input  logic    arstN,
    input  patternT pattern,
    output logic    req,
    output rgbT     data,
    input  logic    ack
);

    localparam int xW = (hDisplay > 1) ? $clog2(hDisplay) : 1;
    localparam int yW = (vDisplay > 1) ? $clog2(vDisplay) : 1;

    // Waiting for ack to fall, or holding req until ack rises
    typedef enum logic {
        sRelease = 1'b0,
        sOffer   = 1'b1
    } stateT;

    stateT           state;
    patternT         patternQ;
    logic [xW-1:0]   x;
    logic [yW-1:0]   y;
    logic            launch;

    // A new word goes out once the previous ack has dropped
    assign launch = (state == sRelease) && !ack;

    // Pattern select is captured only while reset is held
    always_ff @(posedge iClk) begin
        if (!arstN) begin
            patternQ <= pattern;
        end
    end

    //------------------------------------------------------------
    // Handshake FSM and position counters
    //------------------------------------------------------------
    always_ff @(posedge iClk or negedge arstN) begin
        if (!arstN) begin
            state <= sRelease;
            req   <= 1'b0;
            x     <= '0;
            y     <= '0;
        end else begin
            case (state)
                sRelease: begin
                    if (!ack) begin
                        req   <= 1'b1;
                        state <= sOffer;
                    end
                end
                sOffer: begin
                    if (ack) begin
                        req   <= 1'b0;
                        state <= sRelease;
                        // Next position, wrapping at the frame end
                        if (x == xW'(hDisplay - 1)) begin
                            x <= '0;
                            y <= (y == yW'(vDisplay - 1)) ? '0 : y + 1'b1;
                        end else begin
                            x <= x + 1'b1;
                        end
                    end
                end
                default: begin
                    state <= sRelease;
                end
            endcase
        end
    end

    // Payload is loaded with req and held until ack
    always_ff @(posedge iClk) begin
        if (launch) begin
            data <= patternPixel(patternQ, x, y, hDisplay);
        end
    end

endmodule

//--- videoPkg.sv
/*
 * Shared video definitions for the display front end.
 * Holds the pixel type, the picture pattern codes and the pattern rule.
 * The pattern source and the testbench model both call patternPixel,
 * so the picture content is defined once.
 */
package videoPkg;

    // 24 bit pixel, red in the top byte
    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgbT;

    typedef enum logic [1:0] {
        patGradient = 2'd0,
        patBars     = 2'd1,
        patChecker  = 2'd2,
        patSolid    = 2'd3
    } patternT;

    //------------------------------------------------------------
    // Pixel value at (x, y) of the active area
    //------------------------------------------------------------
    function automatic rgbT patternPixel(patternT pattern, int x, int y, int hDisplay);
        rgbT px;
        int  bar;
        px  = '0;
        bar = (x * 8) / hDisplay;
        case (pattern)
            patGradient: begin
                px.red   = x[7:0];
                px.green = y[7:0];
                px.blue  = x[7:0] ^ y[7:0];
            end
            patBars: begin
                // Eight bars, colour bits taken from the bar index
                px.red   = bar[2] ? 8'hFF : 8'h00;
                px.green = bar[1] ? 8'hFF : 8'h00;
                px.blue  = bar[0] ? 8'hFF : 8'h00;
            end
            patChecker: begin
                px = (x[2] ^ y[2]) ? rgbT'(24'hFFFFFF) : rgbT'(24'h000000);
            end
            default: begin
                px = rgbT'(24'h808080);
            end
        endcase
        return px;
    endfunction

endpackage
